// File: src/rv32i_pkg.sv
package rv32i_pkg;

    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // major opcodes still handled by the pipe
    typedef enum logic [6:0] {
        op_reg = 7'b0110011,
        op_imm = 7'b0010011,
        op_lui = 7'b0110111
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    // operand source for the ALU inputs
    typedef enum logic [1:0] {
        fwd_rf,     // register file read
        fwd_ex_mem, // one instruction ahead
        fwd_mem_wb  // two instructions ahead
    } fwd_sel_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    use_imm; // operand 2 comes from imm
        logic    is_lui;
    } ctrl_word_t;

    // ID/EX stage payload
    typedef struct packed {
        logic       valid;
        ctrl_word_t ctrl;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        word_t      imm;  // sign extended, or upper 20 bits for lui
    } id_ex_t;

    // EX/MEM, MEM/WB and retire payload
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } result_t;

endpackage

// File: src/inst_decoder.sv
module inst_decoder import rv32i_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   hold,
    input  logic   inst_valid,
    input  word_t  inst,
    output id_ex_t id_ex
);

    opcode_t  opcode;
    logic [2:0] funct3;
    logic     bit30;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    imm_i;
    word_t    imm_u;
    alu_op_t  alu_op;
    id_ex_t   dec;

    assign opcode = opcode_t'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign bit30  = inst[30];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign rd     = inst[11:7];
    assign imm_i  = {{20{inst[31]}}, inst[31:20]};
    assign imm_u  = {inst[31:12], 12'h000};

    // funct3 map is shared by register and immediate forms
    always_comb
    begin
        unique case (funct3)
            3'b000: alu_op = (bit30 && opcode == op_reg) ? alu_sub : alu_add; // no subi
            3'b001: alu_op = alu_sll;
            3'b010: alu_op = alu_slt;
            3'b011: alu_op = alu_sltu;
            3'b100: alu_op = alu_xor;
            3'b101: alu_op = bit30 ? alu_sra : alu_srl;
            3'b110: alu_op = alu_or;
            default: alu_op = alu_and;
        endcase
    end

    always_comb
    begin
        dec              = '0;
        dec.rd           = rd;
        dec.ctrl.alu_op  = alu_op;
        case (opcode)
            op_reg:
            begin
                dec.valid = inst_valid;
                dec.rs1   = rs1;
                dec.rs2   = rs2;
            end
            op_imm:
            begin
                dec.valid        = inst_valid;
                dec.rs1          = rs1;
                dec.ctrl.use_imm = 1'b1;
                dec.imm          = imm_i;
            end
            op_lui:
            begin
                dec.valid       = inst_valid;
                dec.ctrl.is_lui = 1'b1;
                dec.imm         = imm_u;
            end
            default: ; // unknown opcode, bubble
        endcase
        if (rd == '0)
            dec.valid = 1'b0; // result would be thrown away
    end

    // ID/EX register
    always_ff @(posedge clk)
    begin
        if (reset)
            id_ex.valid <= 1'b0;
        else if (!hold)
            id_ex <= dec;
    end

endmodule

// File: src/reg_file.sv
module reg_file import rv32i_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  id_ex_t  id_ex,
    input  result_t wb,
    output word_t   rs1_data,
    output word_t   rs2_data
);

    word_t regs [1:31]; // x0 is not stored

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wb.valid && wb.rd != '0)
        begin
            regs[wb.rd] <= wb.data;
        end
    end

    // no write-through here, MEM/WB forward covers it
    assign rs1_data = (id_ex.rs1 == '0) ? '0 : regs[id_ex.rs1];
    assign rs2_data = (id_ex.rs2 == '0) ? '0 : regs[id_ex.rs2];

endmodule

// File: src/forward_unit.sv
module forward_unit import rv32i_pkg::*;
(
    input  id_ex_t   id_ex,
    input  result_t  ex_mem,
    input  result_t  mem_wb,
    output fwd_sel_t fwd_a,
    output fwd_sel_t fwd_b
);

    // newest producer wins; valid entries never carry rd x0
    function automatic fwd_sel_t pick_src(input reg_idx_t src,
                                          input result_t  ex_mem_e,
                                          input result_t  mem_wb_e);
        fwd_sel_t sel;
        sel = fwd_rf;
        if (ex_mem_e.valid && ex_mem_e.rd == src)
            sel = fwd_ex_mem;
        else if (mem_wb_e.valid && mem_wb_e.rd == src)
            sel = fwd_mem_wb;
        return sel;
    endfunction

    assign fwd_a = pick_src(id_ex.rs1, ex_mem, mem_wb);
    assign fwd_b = pick_src(id_ex.rs2, ex_mem, mem_wb);

endmodule

// File: src/execute_stage.sv
module execute_stage import rv32i_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     hold,
    input  id_ex_t   id_ex,
    input  word_t    rs1_data,
    input  word_t    rs2_data,
    input  fwd_sel_t fwd_a,
    input  fwd_sel_t fwd_b,
    output result_t  ex_mem,
    output result_t  mem_wb,
    output result_t  retire
);

    word_t      op_a;
    word_t      op_b_fwd;
    word_t      op_b;
    word_t      alu_out;
    logic [4:0] shamt;
    result_t    ex_result;

    // forwarded operand values
    always_comb
    begin
        unique case (fwd_a)
            fwd_ex_mem: op_a = ex_mem.data;
            fwd_mem_wb: op_a = mem_wb.data;
            default:    op_a = rs1_data;
        endcase
        unique case (fwd_b)
            fwd_ex_mem: op_b_fwd = ex_mem.data;
            fwd_mem_wb: op_b_fwd = mem_wb.data;
            default:    op_b_fwd = rs2_data;
        endcase
    end

    assign op_b  = id_ex.ctrl.use_imm ? id_ex.imm : op_b_fwd;
    assign shamt = op_b[4:0];

    always_comb
    begin
        unique case (id_ex.ctrl.alu_op)
            alu_add:  alu_out = op_a + op_b;
            alu_sub:  alu_out = op_a - op_b;
            alu_sll:  alu_out = op_a << shamt;
            alu_slt:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_sltu: alu_out = {31'b0, op_a < op_b};
            alu_xor:  alu_out = op_a ^ op_b;
            alu_srl:  alu_out = op_a >> shamt;
            alu_sra:  alu_out = word_t'($signed(op_a) >>> shamt);
            alu_or:   alu_out = op_a | op_b;
            default:  alu_out = op_a & op_b;
        endcase
    end

    always_comb
    begin
        ex_result.valid = id_ex.valid;
        ex_result.rd    = id_ex.rd;
        ex_result.data  = id_ex.ctrl.is_lui ? id_ex.imm : alu_out;
    end

    // EX/MEM and MEM/WB registers, frozen together by hold
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ex_mem.valid <= 1'b0;
            mem_wb.valid <= 1'b0;
        end
        else if (!hold)
        begin
            ex_mem <= ex_result;
            mem_wb <= ex_mem;
        end
    end

    // entry stays in MEM/WB while held, so only report it on a moving edge
    always_comb
    begin
        retire       = mem_wb;
        retire.valid = mem_wb.valid & ~hold;
    end

endmodule

// File: src/exec_pipe_top.sv
module exec_pipe_top import rv32i_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    hold,
    input  logic    inst_valid,
    input  word_t   inst,
    output result_t retire
);

    id_ex_t   id_ex;
    word_t    rs1_data;
    word_t    rs2_data;
    result_t  ex_mem;
    result_t  mem_wb;
    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;

    inst_decoder u_decoder (
        .clk        (clk),
        .reset      (reset),
        .hold       (hold),
        .inst_valid (inst_valid),
        .inst       (inst),
        .id_ex      (id_ex)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .reset    (reset),
        .id_ex    (id_ex),
        .wb       (retire), // write port is the retire entry
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    forward_unit u_forward_unit (
        .id_ex  (id_ex),
        .ex_mem (ex_mem),
        .mem_wb (mem_wb),
        .fwd_a  (fwd_a),
        .fwd_b  (fwd_b)
    );

    execute_stage u_execute (
        .clk      (clk),
        .reset    (reset),
        .hold     (hold),
        .id_ex    (id_ex),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .fwd_a    (fwd_a),
        .fwd_b    (fwd_b),
        .ex_mem   (ex_mem),
        .mem_wb   (mem_wb),
        .retire   (retire)
    );

endmodule

// File: testbench/exec_pipe_tb.sv
module exec_pipe_tb import rv32i_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int LATENCY    = 3;
    localparam int MAX_CYCLES = 16 + 30 + 110 + 60 + 60 + 100 + 700 + 200; // tests plus margin

    typedef struct packed {
        reg_idx_t rd;
        word_t    data;
        int       due; // 0 when latency is not checked
    } exp_t;

    logic    clk;
    logic    reset;
    logic    hold;
    logic    inst_valid;
    word_t   inst;
    result_t retire;

    word_t   model_rf [32];
    exp_t    exp_q [$];
    exp_t    head;
    int      cycle;
    int      errors;
    int      err_mark;
    logic    check_lat;

    exec_pipe_top u_exec_pipe_top (
        .clk        (clk),
        .reset      (reset),
        .hold       (hold),
        .inst_valid (inst_valid),
        .inst       (inst),
        .retire     (retire)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // sampled before the edge updates anything
    always @(posedge clk)
    begin
        if (!reset && retire.valid)
        begin
            assert (exp_q.size() != 0)
            else
            begin
                errors++;
                $display("%0t: x%0d retired with nothing outstanding", $time, retire.rd);
            end
            if (exp_q.size() != 0)
            begin
                head = exp_q.pop_front();
                assert (retire.rd == head.rd)
                else
                begin
                    errors++;
                    $display("** Error %0t: retire.rd expected %0d got %0d",
                             $time, head.rd, retire.rd);
                end
                assert (retire.data == head.data)
                else
                begin
                    errors++;
                    $display("** Error %0t: retire.data expected %h got %h",
                             $time, head.data, retire.data);
                end
                assert (head.due == 0 || cycle == head.due)
                else
                begin
                    errors++;
                    $display("%0t: x%0d retired in cycle %0d instead of cycle %0d",
                             $time, head.rd, cycle, head.due);
                end
            end
        end
        assert (!(hold && retire.valid))
        else
        begin
            errors++;
            $display("%0t: retire is valid while hold is high", $time);
        end
        cycle++;
        if (cycle > MAX_CYCLES)
        begin
            $display("timeout: run did not end within %0d cycles", MAX_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic word_t alu(input logic [2:0] f3, input logic alt,
                                  input word_t a, input word_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << sh;
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? 32'($signed(a) >>> sh) : a >> sh;
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // in-order reference, run when the instruction is taken
    task automatic model(input word_t w);
        reg_idx_t rd;
        word_t    a;
        word_t    r;
        logic     ok;
        rd = w[11:7];
        a  = model_rf[w[19:15]];
        ok = 1'b1;
        case (w[6:0])
            7'b0110011: r = alu(w[14:12], w[30], a, model_rf[w[24:20]]);
            7'b0010011: r = alu(w[14:12], w[30] && w[14:12] == 3'd5, a,
                                {{20{w[31]}}, w[31:20]});
            7'b0110111: r = {w[31:12], 12'h000};
            default:    ok = 1'b0;
        endcase
        if (ok && rd != 5'd0)
        begin
            model_rf[rd] = r;
            exp_q.push_back('{rd, r, check_lat ? cycle + LATENCY : 0});
        end
    endtask

    function automatic word_t enc_r(input int idx, input reg_idx_t rd,
                                    input reg_idx_t rs1, input reg_idx_t rs2);
        logic [2:0] f3;
        case (idx)
            0, 1:    f3 = 3'd0;
            2:       f3 = 3'd1;
            3:       f3 = 3'd2;
            4:       f3 = 3'd3;
            5:       f3 = 3'd4;
            6, 7:    f3 = 3'd5;
            8:       f3 = 3'd6;
            default: f3 = 3'd7;
        endcase
        return {1'b0, idx == 1 || idx == 7, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    // idx: addi slti sltiu xori ori andi slli srli srai
    function automatic word_t enc_i(input int idx, input reg_idx_t rd,
                                    input reg_idx_t rs1, input logic [11:0] imm);
        logic [2:0]  f3;
        logic [11:0] i12;
        i12 = imm;
        case (idx)
            0:       f3 = 3'd0;
            1:       f3 = 3'd2;
            2:       f3 = 3'd3;
            3:       f3 = 3'd4;
            4:       f3 = 3'd6;
            5:       f3 = 3'd7;
            6:       f3 = 3'd1;
            default: f3 = 3'd5;
        endcase
        if (idx >= 6)
            i12 = {1'b0, idx == 8, 5'b0, imm[4:0]}; // shamt form
        return {i12, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic reg_idx_t rreg();
        return 5'($urandom % 8); // few regs, lots of hazards
    endfunction

    function automatic word_t rand_inst();
        int k;
        k = $urandom % 20;
        if (k < 8)
            return enc_r($urandom % 10, rreg(), rreg(), rreg());
        else if (k < 15)
            return enc_i($urandom % 9, rreg(), rreg(), 12'($urandom));
        else if (k < 17)
            return {20'($urandom), rreg(), 7'b0110111};
        else if (k < 18)
            return {25'($urandom), 7'b0000011}; // load, not handled
        else
            return enc_r($urandom % 10, 5'd0, rreg(), rreg());
    endfunction

    task automatic drive(input logic v, input word_t w, input logic h);
        @(negedge clk);
        inst_valid = v;
        inst       = w;
        hold       = h;
        if (v && !h)
            model(w);
    endtask

    task automatic finish_test(input string name);
        int waited;
        waited = 0;
        // with hold low every entry leaves within the pipe latency
        while (exp_q.size() != 0 && waited < LATENCY + 2)
        begin
            drive(1'b0, '0, 1'b0);
            waited++;
        end
        assert (exp_q.size() == 0)
        else
        begin
            errors++;
            $display("%s: results still outstanding at the end", name);
            exp_q.delete();
        end
        repeat (5) drive(1'b0, '0, 1'b0); // stray retires show up here
        $display("test %s done, %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    initial
    begin
        int       seed;
        int       taken;
        logic     h;
        logic     v;
        reg_idx_t hist [3];
        reg_idx_t rd;
        seed       = $urandom(92);
        reset      = 1'b1;
        hold       = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        check_lat  = 1'b1;
        cycle      = 0;
        errors     = 0;
        err_mark   = 0;
        for (int i = 0; i < 32; i++)
            model_rf[i] = '0;
        repeat (16) @(negedge clk);
        reset = 1'b0;

        // unwritten source reads zero
        repeat (5) drive(1'b0, '0, 1'b0);
        drive(1'b1, enc_i(0, 5'd5, 5'd5, 12'h07b), 1'b0);
        finish_test("reset");

        for (int i = 0; i < 18; i++)
        begin
            if (i % 9 == 8 && i > 9)
                drive(1'b1, {20'($urandom), 5'($urandom % 31 + 1), 7'b0110111}, 1'b0);
            else
                drive(1'b1, enc_i(i % 9, 5'($urandom % 31 + 1), rreg(), 12'($urandom)), 1'b0);
            repeat (4) drive(1'b0, '0, 1'b0);
        end
        finish_test("immediate");

        hist[0] = 5'd1;
        hist[1] = 5'd2;
        hist[2] = 5'd3;
        for (int i = 0; i < 40; i++)
        begin
            rd = 5'($urandom % 7 + 1);
            drive(1'b1, enc_r($urandom % 10, rd, hist[$urandom % 3], hist[$urandom % 3]), 1'b0);
            hist[2] = hist[1];
            hist[1] = hist[0];
            hist[0] = rd;
        end
        finish_test("chains");

        for (int i = 0; i < 10; i++)
        begin
            drive(1'b1, enc_r($urandom % 10, 5'd0, rreg(), rreg()), 1'b0);
            drive(1'b1, {25'($urandom), 7'b1100011}, 1'b0); // branch opcode
            drive(1'b1, enc_r($urandom % 10, 5'd6, 5'd0, 5'd0), 1'b0);
            drive(1'b1, enc_i($urandom % 9, 5'd7, 5'd0, 12'($urandom)), 1'b0);
        end
        finish_test("x0");

        check_lat = 1'b0; // hold stretches the latency
        for (int i = 0; i < 80; i++)
        begin
            h = ($urandom % 3 == 0);
            drive(1'b1, rand_inst(), h);
        end
        finish_test("hold");

        taken = 0;
        while (taken < 300)
        begin
            h = ($urandom % 4 == 0);
            v = ($urandom % 3 != 0);
            drive(v, rand_inst(), h);
            if (v && !h)
                taken++;
        end
        finish_test("mixed");

        $display("summary: %0d cycles, %0d errors", cycle, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: sim.f
src/rv32i_pkg.sv
src/inst_decoder.sv
src/reg_file.sv
src/forward_unit.sv
src/execute_stage.sv
src/exec_pipe_top.sv
testbench/exec_pipe_tb.sv

// File: run.sh
#!/bin/sh
# build and run the execute pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module exec_pipe_tb -o exec_pipe_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/exec_pipe_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "PASS: all tests" sim.log; then
    exit 0
fi
exit 1
